// File: pit_pkg.sv
// Shared codes for the PIT; the select field is two bits, so the channel count is fixed at 3
package pit_pkg;

	localparam int NUM_CH = 3;
	localparam int BYTE_W = 8;

	// Counter select field of the control word
	localparam logic [1:0] SEL_CH0  = 2'd0;
	localparam logic [1:0] SEL_CH1  = 2'd1;
	localparam logic [1:0] SEL_CH2  = 2'd2;
	// Reserved on the 8253
	localparam logic [1:0] SEL_NONE = 2'd3;

	// Read/write format field
	localparam logic [1:0] RW_LATCH = 2'd0;
	localparam logic [1:0] RW_LSB   = 2'd1;
	localparam logic [1:0] RW_MSB   = 2'd2;
	localparam logic [1:0] RW_BOTH  = 2'd3;

	// Supported modes, 6 and 7 fold onto 2 and 3
	localparam logic [2:0] MODE_TC     = 3'd0;
	localparam logic [2:0] MODE_RATE   = 3'd2;
	localparam logic [2:0] MODE_SQUARE = 3'd3;

	// {a1, a0} of the control word register
	localparam logic [1:0] ADDR_CTRL = 2'b11;

	typedef struct packed {
		logic [1:0] sel;
		logic [1:0] rw;
		logic [2:0] mode;
		logic       bcd;
	} pit_ctrl_word_t;

	// Latch command shares the select field, rw field reads as RW_LATCH
	typedef struct packed {
		logic [1:0] sel;
		logic [1:0] code;
		logic [3:0] unused;
	} pit_latch_cmd_t;

	typedef union packed {
		pit_ctrl_word_t word;
		pit_latch_cmd_t latch;
	} pit_ctrl_u;

endpackage

// File: pit_bus_decode.sv
// Strobes are one ZCLK late; wr_n must be low for at least one ZCLK and reads of address 3 are ignored
`timescale 1ns/1ps

module pit_bus_decode import pit_pkg::*; (
	input  logic              ZCLK,
	input  logic              rst_n,
	input  logic              cs_n,
	input  logic              rd_n,
	input  logic              wr_n,
	input  logic              a0,
	input  logic              a1,
	input  logic [BYTE_W-1:0] d_in,
	output logic [NUM_CH-1:0] ctrl_wr,
	output logic [NUM_CH-1:0] latch_cmd,
	output logic [NUM_CH-1:0] count_wr,
	output logic [NUM_CH-1:0] rd_start,
	output logic [NUM_CH-1:0] rd_end,
	output pit_ctrl_u         ctrl,
	output logic [BYTE_W-1:0] wr_data
);

	logic              wr_q;
	logic              rd_q;
	logic              wr_fire;
	logic              rd_fall;
	logic              rd_rise;
	logic              is_ctrl;
	logic [1:0]        addr;
	logic [NUM_CH-1:0] rd_ch;
	pit_ctrl_u         d_word;

	// Select code to one channel bit, the reserved code hits nothing
	function automatic logic [NUM_CH-1:0] sel_onehot(input logic [1:0] s);
		logic [NUM_CH-1:0] oh;
		oh = '0;
		case (s)
			SEL_CH0:  oh[0] = 1'b1;
			SEL_CH1:  oh[1] = 1'b1;
			SEL_CH2:  oh[2] = 1'b1;
			SEL_NONE: oh = '0;
			default:  oh = '0;
		endcase
		return oh;
	endfunction

	assign addr    = {a1, a0};
	assign is_ctrl = (addr == ADDR_CTRL);
	assign d_word  = d_in;
	assign wr_fire = !wr_n && wr_q && !cs_n && rd_n;
	assign rd_fall = !rd_n && rd_q && !cs_n;
	assign rd_rise = rd_n && !rd_q;

	always_ff @(posedge ZCLK or negedge rst_n) begin
		if (!rst_n) begin
			wr_q      <= 1'b1;
			rd_q      <= 1'b1;
			ctrl_wr   <= '0;
			latch_cmd <= '0;
			count_wr  <= '0;
			rd_start  <= '0;
			rd_end    <= '0;
			rd_ch     <= '0;
		end else begin
			wr_q <= wr_n;
			rd_q <= rd_n;
			// Same byte read as control word or as latch command
			ctrl_wr   <= (wr_fire && is_ctrl && d_word.word.rw != RW_LATCH) ?
				sel_onehot(d_word.word.sel) : '0;
			latch_cmd <= (wr_fire && is_ctrl && d_word.latch.code == RW_LATCH) ?
				sel_onehot(d_word.latch.sel) : '0;
			count_wr  <= (wr_fire && !is_ctrl) ? sel_onehot(addr) : '0;
			rd_start  <= rd_fall ? sel_onehot(addr) : '0;
			rd_end    <= rd_rise ? rd_ch : '0;
			// Remember the channel so the end pulse hits the same one
			if (rd_fall)
				rd_ch <= sel_onehot(addr);
			else if (rd_rise)
				rd_ch <= '0;
		end
	end

	always_ff @(posedge ZCLK) begin
		if (wr_fire && is_ctrl)
			ctrl <= d_word;
		if (wr_fire)
			wr_data <= d_in;
	end

endmodule

// File: pit_clk_sync.sv
// Counter clocks must stay high and low for more than SYNC_STAGES ZCLK cycles each
`timescale 1ns/1ps

module pit_clk_sync import pit_pkg::*; #(
	parameter int SYNC_STAGES = 2
) (
	input  logic              ZCLK,
	input  logic              rst_n,
	input  logic [NUM_CH-1:0] clk,
	input  logic [NUM_CH-1:0] gate,
	output logic [NUM_CH-1:0] tick,
	output logic [NUM_CH-1:0] gate_s
);

	logic [SYNC_STAGES-1:0][NUM_CH-1:0] clk_pipe;
	logic [SYNC_STAGES-1:0][NUM_CH-1:0] gate_pipe;
	logic [NUM_CH-1:0]                  clk_d;

	assign gate_s = gate_pipe[SYNC_STAGES-1];

	always_ff @(posedge ZCLK or negedge rst_n) begin
		if (!rst_n) begin
			clk_pipe  <= '0;
			gate_pipe <= '0;
			clk_d     <= '0;
			tick      <= '0;
		end else begin
			clk_pipe[0]  <= clk;
			gate_pipe[0] <= gate;
			for (int i = 1; i < SYNC_STAGES; i++) begin
				clk_pipe[i]  <= clk_pipe[i-1];
				gate_pipe[i] <= gate_pipe[i-1];
			end
			clk_d <= clk_pipe[SYNC_STAGES-1];
			// Rising edge of the synchronized clock, one pulse each
			tick  <= clk_pipe[SYNC_STAGES-1] & ~clk_d;
		end
	end

endmodule

// File: pit_count_load.sv
// COUNT_W must be two bytes; rw and mode take effect the cycle after ctrl_wr
`timescale 1ns/1ps

module pit_count_load import pit_pkg::*; #(
	parameter int COUNT_W = 16
) (
	input  logic               ZCLK,
	input  logic               rst_n,
	input  logic               ctrl_wr,
	input  logic               count_wr,
	input  pit_ctrl_u          ctrl,
	input  logic [BYTE_W-1:0]  wr_data,
	output logic [2:0]         mode,
	output logic [1:0]         rw,
	output logic [COUNT_W-1:0] count_value,
	output logic               armed,
	output logic               new_count
);

	// High once the LSB of a two byte write has landed
	logic byte_hi;

	always_ff @(posedge ZCLK or negedge rst_n) begin
		if (!rst_n) begin
			mode      <= MODE_TC;
			rw        <= RW_LSB;
			armed     <= 1'b0;
			byte_hi   <= 1'b0;
			new_count <= 1'b0;
		end else begin
			new_count <= 1'b0;
			if (ctrl_wr) begin
				rw      <= ctrl.word.rw;
				// Modes 6 and 7 are 2 and 3 with bit 2 set
				mode    <= ctrl.word.mode[1] ? {1'b0, ctrl.word.mode[1:0]} : ctrl.word.mode;
				armed   <= 1'b0;
				byte_hi <= 1'b0;
			end else if (count_wr) begin
				case (rw)
					RW_LSB, RW_MSB: begin
						armed     <= 1'b1;
						new_count <= 1'b1;
					end
					RW_BOTH: begin
						byte_hi <= ~byte_hi;
						if (byte_hi) begin
							armed     <= 1'b1;
							new_count <= 1'b1;
						end
					end
					default: ;
				endcase
			end
		end
	end

	// Count register itself
	always_ff @(posedge ZCLK) begin
		if (count_wr && !ctrl_wr) begin
			case (rw)
				RW_LSB: begin
					count_value                     <= '0;
					count_value[BYTE_W-1:0]         <= wr_data;
				end
				RW_MSB: begin
					count_value                     <= '0;
					count_value[COUNT_W-1 -: BYTE_W] <= wr_data;
				end
				RW_BOTH: begin
					if (byte_hi)
						count_value[COUNT_W-1 -: BYTE_W] <= wr_data;
					else
						count_value[BYTE_W-1:0] <= wr_data;
				end
				default: ;
			endcase
		end
	end

endmodule

// File: pit_down_counter.sv
// Binary counting only; modes 1, 4 and 5 stay idle and a new count loads on the next tick
`timescale 1ns/1ps

module pit_down_counter import pit_pkg::*; #(
	parameter int COUNT_W = 16
) (
	input  logic               ZCLK,
	input  logic               rst_n,
	input  logic               tick,
	input  logic               gate_s,
	input  logic [2:0]         mode,
	input  logic [COUNT_W-1:0] count_value,
	input  logic               armed,
	input  logic               new_count,
	input  logic               ctrl_wr,
	output logic [COUNT_W-1:0] count,
	output logic               out
);

	logic               pending;
	logic               active;
	logic               out_r;
	logic               supported;
	logic               init_level;
	logic [COUNT_W-1:0] reload_v;
	logic [COUNT_W-1:0] load_v;
	logic [COUNT_W-1:0] cnt_dec;

	// Output level that goes with a given count
	function automatic logic out_level(
		input logic [2:0]         m,
		input logic [COUNT_W-1:0] c,
		input logic [COUNT_W-1:0] rv
	);
		case (m)
			MODE_TC:     return (c == '0);
			MODE_RATE:   return (c != COUNT_W'(1));
			MODE_SQUARE: return (c > (rv >> 1));
			default:     return 1'b0;
		endcase
	endfunction

	assign supported  = (mode == MODE_TC) || (mode == MODE_RATE) || (mode == MODE_SQUARE);
	assign init_level = (mode == MODE_RATE) || (mode == MODE_SQUARE);
	// Zero stands for the full range
	assign load_v     = (count_value == '0) ? '1 : count_value;
	assign out        = active ? out_r : init_level;

	always_comb begin
		if (mode == MODE_TC)
			cnt_dec = (count == '0) ? '0 : count - 1'b1;
		else
			cnt_dec = (count == COUNT_W'(1)) ? reload_v : count - 1'b1;
	end

	always_ff @(posedge ZCLK or negedge rst_n) begin
		if (!rst_n) begin
			pending <= 1'b0;
			active  <= 1'b0;
			out_r   <= 1'b0;
			count   <= '0;
		end else begin
			if (ctrl_wr) begin
				pending <= 1'b0;
				active  <= 1'b0;
				out_r   <= 1'b0;
			end else if (tick) begin
				if (pending && armed && supported) begin
					// Load tick
					count   <= load_v;
					pending <= 1'b0;
					active  <= 1'b1;
					out_r   <= out_level(mode, load_v, load_v);
				end else if (active && gate_s) begin
					count <= cnt_dec;
					out_r <= out_level(mode, cnt_dec, reload_v);
				end else if (active && mode != MODE_TC) begin
					out_r <= 1'b1;
				end
			end
			if (new_count)
				pending <= 1'b1;
		end
	end

	// Reload value is fixed at the load tick, later writes wait for the next one
	always_ff @(posedge ZCLK) begin
		if (tick && pending && armed && supported && !ctrl_wr)
			reload_v <= load_v;
	end

endmodule

// File: pit_read_port.sv
// COUNT_W must be two bytes; a second latch command is ignored until the held value is read
`timescale 1ns/1ps

module pit_read_port import pit_pkg::*; #(
	parameter int COUNT_W = 16
) (
	input  logic                            ZCLK,
	input  logic                            rst_n,
	input  logic [NUM_CH-1:0]               latch_cmd,
	input  logic [NUM_CH-1:0]               ctrl_wr,
	input  logic [NUM_CH-1:0]               rd_start,
	input  logic [NUM_CH-1:0]               rd_end,
	input  logic [NUM_CH-1:0][1:0]          rw,
	input  logic [NUM_CH-1:0][COUNT_W-1:0]  count,
	output logic [BYTE_W-1:0]               d_out,
	output logic                            d_oe
);

	logic [NUM_CH-1:0][COUNT_W-1:0] latch_v;
	logic [NUM_CH-1:0]              held;
	logic [NUM_CH-1:0]              hi_byte;
	logic [NUM_CH-1:0]              rd_act;
	logic [NUM_CH-1:0]              rd_sel;

	// Read window opens with the start pulse and closes after the end pulse
	assign rd_sel = rd_start | rd_act;
	assign d_oe   = |rd_sel;

	always_ff @(posedge ZCLK or negedge rst_n) begin
		if (!rst_n) begin
			held    <= '0;
			hi_byte <= '0;
			rd_act  <= '0;
		end else begin
			for (int i = 0; i < NUM_CH; i++) begin
				if (ctrl_wr[i]) begin
					held[i]    <= 1'b0;
					hi_byte[i] <= 1'b0;
				end else begin
					if (latch_cmd[i])
						held[i] <= 1'b1;
					if (rd_end[i]) begin
						if (rw[i] == RW_BOTH) begin
							hi_byte[i] <= ~hi_byte[i];
							// Release after the MSB
							if (hi_byte[i])
								held[i] <= 1'b0;
						end else begin
							held[i] <= 1'b0;
						end
					end
				end
				if (rd_start[i])
					rd_act[i] <= 1'b1;
				else if (rd_end[i])
					rd_act[i] <= 1'b0;
			end
		end
	end

	// Latch tracks the live count until held
	always_ff @(posedge ZCLK) begin
		for (int i = 0; i < NUM_CH; i++) begin
			if (!held[i])
				latch_v[i] <= count[i];
		end
	end

	always_comb begin
		d_out = '0;
		for (int i = 0; i < NUM_CH; i++) begin
			if (rd_sel[i]) begin
				if (rw[i] == RW_MSB || (rw[i] == RW_BOTH && hi_byte[i]))
					d_out = d_out | latch_v[i][COUNT_W-1 -: BYTE_W];
				else
					d_out = d_out | latch_v[i][BYTE_W-1:0];
			end
		end
	end

endmodule

// File: pit_8253.sv
// Everything runs on ZCLK; clk and gate are sampled levels and must be slower than ZCLK / 2*SYNC_STAGES
`timescale 1ns/1ps

module pit_8253 import pit_pkg::*; #(
	parameter int COUNT_W     = 16,
	parameter int SYNC_STAGES = 2
) (
	input  logic              ZCLK,
	input  logic              rst_n,
	input  logic              cs_n,
	input  logic              rd_n,
	input  logic              wr_n,
	input  logic              a0,
	input  logic              a1,
	input  logic [BYTE_W-1:0] d_in,
	input  logic [NUM_CH-1:0] clk,
	input  logic [NUM_CH-1:0] gate,
	output logic [BYTE_W-1:0] d_out,
	output logic              d_oe,
	output logic [NUM_CH-1:0] out
);

	logic [NUM_CH-1:0]              ctrl_wr;
	logic [NUM_CH-1:0]              latch_cmd;
	logic [NUM_CH-1:0]              count_wr;
	logic [NUM_CH-1:0]              rd_start;
	logic [NUM_CH-1:0]              rd_end;
	pit_ctrl_u                      ctrl;
	logic [BYTE_W-1:0]              wr_data;
	logic [NUM_CH-1:0]              tick;
	logic [NUM_CH-1:0]              gate_s;
	logic [NUM_CH-1:0][2:0]         mode;
	logic [NUM_CH-1:0][1:0]         rw;
	logic [NUM_CH-1:0][COUNT_W-1:0] count_value;
	logic [NUM_CH-1:0][COUNT_W-1:0] count;
	logic [NUM_CH-1:0]              armed;
	logic [NUM_CH-1:0]              new_count;

	pit_bus_decode pit_bus_decode_inst (
		.ZCLK      (ZCLK),
		.rst_n     (rst_n),
		.cs_n      (cs_n),
		.rd_n      (rd_n),
		.wr_n      (wr_n),
		.a0        (a0),
		.a1        (a1),
		.d_in      (d_in),
		.ctrl_wr   (ctrl_wr),
		.latch_cmd (latch_cmd),
		.count_wr  (count_wr),
		.rd_start  (rd_start),
		.rd_end    (rd_end),
		.ctrl      (ctrl),
		.wr_data   (wr_data)
	);

	pit_clk_sync #(
		.SYNC_STAGES (SYNC_STAGES)
	) pit_clk_sync_inst (
		.ZCLK   (ZCLK),
		.rst_n  (rst_n),
		.clk    (clk),
		.gate   (gate),
		.tick   (tick),
		.gate_s (gate_s)
	);

	for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
		pit_count_load #(
			.COUNT_W (COUNT_W)
		) pit_count_load_inst (
			.ZCLK        (ZCLK),
			.rst_n       (rst_n),
			.ctrl_wr     (ctrl_wr[i]),
			.count_wr    (count_wr[i]),
			.ctrl        (ctrl),
			.wr_data     (wr_data),
			.mode        (mode[i]),
			.rw          (rw[i]),
			.count_value (count_value[i]),
			.armed       (armed[i]),
			.new_count   (new_count[i])
		);

		pit_down_counter #(
			.COUNT_W (COUNT_W)
		) pit_down_counter_inst (
			.ZCLK        (ZCLK),
			.rst_n       (rst_n),
			.tick        (tick[i]),
			.gate_s      (gate_s[i]),
			.mode        (mode[i]),
			.count_value (count_value[i]),
			.armed       (armed[i]),
			.new_count   (new_count[i]),
			.ctrl_wr     (ctrl_wr[i]),
			.count       (count[i]),
			.out         (out[i])
		);
	end

	pit_read_port #(
		.COUNT_W (COUNT_W)
	) pit_read_port_inst (
		.ZCLK      (ZCLK),
		.rst_n     (rst_n),
		.latch_cmd (latch_cmd),
		.ctrl_wr   (ctrl_wr),
		.rd_start  (rd_start),
		.rd_end    (rd_end),
		.rw        (rw),
		.count     (count),
		.d_out     (d_out),
		.d_oe      (d_oe)
	);

endmodule

// File: pit_8253_props.sv
// Bound into pit_8253; checks assume the default bus timing and are inactive during reset
`timescale 1ns/1ps

module pit_8253_props import pit_pkg::*; #(
	parameter int COUNT_W = 16
) (
	input logic                           ZCLK,
	input logic                           rst_n,
	input logic                           cs_n,
	input logic                           d_oe,
	input logic [NUM_CH-1:0]              tick,
	input logic [NUM_CH-1:0]              gate_s,
	input logic [NUM_CH-1:0]              ctrl_wr,
	input logic [NUM_CH-1:0][COUNT_W-1:0] count,
	input logic [NUM_CH-1:0][COUNT_W-1:0] count_value,
	input logic [NUM_CH-1:0]              out
);

	for (genvar i = 0; i < NUM_CH; i++) begin : g_prop
		// Output moves only after a tick or a control write
		a_out_src: assert property (@(posedge ZCLK) disable iff (!rst_n)
			$changed(out[i]) |-> $past(tick[i] || ctrl_wr[i]))
			else $error("out[%0d] changed without tick or control write", i);

		// Gate low freezes the count, only a load may change it
		a_gate_hold: assert property (@(posedge ZCLK) disable iff (!rst_n)
			$past(!gate_s[i]) |-> $stable(count[i]) ||
				count[i] == ((count_value[i] == '0) ? '1 : count_value[i]))
			else $error("count[%0d] moved while gate low", i);
	end

	// Read window closes within two cycles once the chip is deselected
	a_oe_cs: assert property (@(posedge ZCLK) disable iff (!rst_n)
		cs_n && $past(cs_n) && $past(cs_n, 2) |-> !d_oe)
		else $error("d_oe high while chip deselected");

endmodule

bind pit_8253 pit_8253_props #(.COUNT_W(COUNT_W)) pit_8253_props_inst (
	.ZCLK        (ZCLK),
	.rst_n       (rst_n),
	.cs_n        (cs_n),
	.d_oe        (d_oe),
	.tick        (tick),
	.gate_s      (gate_s),
	.ctrl_wr     (ctrl_wr),
	.count       (count),
	.count_value (count_value),
	.out         (out)
);

// File: tb_pit_8253.sv
// Counter clock pulses are 8 ZCLK high and 8 low so outputs settle before each check; binary mode only
`timescale 1ns/1ps

module tb_pit_8253 import pit_pkg::*; ();

	localparam int HALF_PER = 2;
	localparam int BUS_TMO  = 20;
	localparam int OP_CFG   = 0;
	localparam int OP_RUN   = 1;
	localparam int OP_GATE  = 2;
	localparam int OP_LATCH = 3;
	localparam int OP_READ  = 4;

	typedef struct {
		int op;
		int ch;
		int rw;
		int mode;
		int val;
		int exp;
	} row_t;

	logic              ZCLK;
	logic              rst_n;
	logic              cs_n;
	logic              rd_n;
	logic              wr_n;
	logic              a0;
	logic              a1;
	logic [BYTE_W-1:0] d_in;
	logic [NUM_CH-1:0] clk;
	logic [NUM_CH-1:0] gate;
	logic [BYTE_W-1:0] d_out;
	logic              d_oe;
	logic [NUM_CH-1:0] out;

	row_t        rows[$];
	int          errors;
	int unsigned seed;
	// Reference model per channel, e counts effective ticks, 0 means not loaded
	int          m_mode[NUM_CH];
	int          m_n[NUM_CH];
	int          m_e[NUM_CH];
	int          m_forced[NUM_CH];

	pit_8253 pit_8253_inst (
		.ZCLK  (ZCLK),
		.rst_n (rst_n),
		.cs_n  (cs_n),
		.rd_n  (rd_n),
		.wr_n  (wr_n),
		.a0    (a0),
		.a1    (a1),
		.d_in  (d_in),
		.clk   (clk),
		.gate  (gate),
		.d_out (d_out),
		.d_oe  (d_oe),
		.out   (out)
	);

	initial begin
		ZCLK = 1'b0;
		forever #(HALF_PER) ZCLK = ~ZCLK;
	end

	function automatic int unsigned lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic row_t mk(int op, int ch, int rw, int mode, int val, int exp);
		row_t r;
		r.op   = op;
		r.ch   = ch;
		r.rw   = rw;
		r.mode = mode;
		r.val  = val;
		r.exp  = exp;
		return r;
	endfunction

	function automatic int model_out(int i);
		if (m_mode[i] != 0 && m_mode[i] != 2 && m_mode[i] != 3)
			return 0;
		if (m_e[i] == 0)
			return (m_mode[i] != 0);
		if (m_forced[i] != 0)
			return 1;
		case (m_mode[i])
			0:       return (m_e[i] >= m_n[i] + 1);
			2:       return ((m_e[i] % m_n[i]) != 0);
			// High for the first ceil(N/2) ticks of each period
			default: return (((m_e[i] - 1) % m_n[i]) < (m_n[i] + 1) / 2);
		endcase
	endfunction

	task automatic check_val(input string name, input int got, input int exp);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t ns %s got 0x%0h expected 0x%0h", $time, name, got, exp);
		end
	endtask

	task automatic check_outs();
		for (int i = 0; i < NUM_CH; i++)
			check_val($sformatf("out[%0d]", i), int'(out[i]), model_out(i));
	endtask

	task automatic bus_write(input logic [1:0] addr, input logic [7:0] data);
		@(negedge ZCLK);
		{a1, a0} = addr;
		d_in     = data;
		cs_n     = 1'b0;
		wr_n     = 1'b0;
		@(negedge ZCLK);
		wr_n = 1'b1;
		cs_n = 1'b1;
		repeat (2) @(negedge ZCLK);
	endtask

	task automatic wait_oe(input logic level, input int ch);
		int n;
		n = 0;
		while (d_oe !== level && n < BUS_TMO) begin
			@(negedge ZCLK);
			n++;
		end
		if (d_oe !== level) begin
			errors++;
			$display("Timeout: d_oe never went to %0b on read of channel %0d", level, ch);
		end
	endtask

	task automatic bus_read(input int ch, output logic [7:0] data);
		@(negedge ZCLK);
		{a1, a0} = 2'(ch);
		cs_n     = 1'b0;
		rd_n     = 1'b0;
		@(negedge ZCLK);
		wait_oe(1'b1, ch);
		data = d_out;
		rd_n = 1'b1;
		@(negedge ZCLK);
		cs_n = 1'b1;
		wait_oe(1'b0, ch);
	endtask

	task automatic configure(input int ch, input int rw, input int mode, input int val);
		pit_ctrl_u cw;
		cw.word.sel  = 2'(ch);
		cw.word.rw   = 2'(rw);
		cw.word.mode = 3'(mode);
		cw.word.bcd  = 1'b0;
		bus_write(ADDR_CTRL, cw);
		m_mode[ch]   = (mode >= 6) ? mode - 4 : mode;
		m_e[ch]      = 0;
		m_forced[ch] = 0;
		case (rw)
			1:       m_n[ch] = val & 'hff;
			2:       m_n[ch] = (val & 'hff) << 8;
			default: m_n[ch] = val & 'hffff;
		endcase
		// Zero stands for the full range
		if (m_n[ch] == 0)
			m_n[ch] = 'hffff;
		if (rw == 2)
			bus_write(2'(ch), 8'(val));
		else
			bus_write(2'(ch), 8'(val & 'hff));
		if (rw == 3)
			bus_write(2'(ch), 8'(val >> 8));
		repeat (2) @(negedge ZCLK);
		check_outs();
	endtask

	// One counter clock pulse on every channel in the mask
	task automatic clk_pulse(input int mask);
		@(negedge ZCLK);
		clk = clk | 3'(mask);
		repeat (8) @(negedge ZCLK);
		clk = clk & ~3'(mask);
		repeat (8) @(negedge ZCLK);
		for (int i = 0; i < NUM_CH; i++) begin
			if (mask[i]) begin
				if (m_e[i] == 0) begin
					m_e[i] = 1;
				end else if (gate[i]) begin
					m_e[i]++;
					m_forced[i] = 0;
				end else if (m_mode[i] != 0) begin
					m_forced[i] = 1;
				end
			end
		end
		check_outs();
	endtask

	task automatic latch_count(input int ch);
		pit_ctrl_u cw;
		cw.latch.sel    = 2'(ch);
		cw.latch.code   = RW_LATCH;
		cw.latch.unused = '0;
		bus_write(ADDR_CTRL, cw);
	endtask

	task automatic apply_row(input row_t r);
		logic [7:0] rd;
		int         n;
		case (r.op)
			OP_CFG:   configure(r.ch, r.rw, r.mode, r.val);
			OP_RUN: begin
				n = (r.val < 0) ? 2 + int'((lcg_next() >> 16) % 4) : r.val;
				repeat (n) clk_pulse(r.ch);
			end
			OP_GATE: begin
				@(negedge ZCLK);
				gate[r.ch] = r.val[0];
				repeat (4) @(negedge ZCLK);
			end
			OP_LATCH: latch_count(r.ch);
			default: begin
				bus_read(r.ch, rd);
				check_val($sformatf("d_out ch%0d", r.ch), int'(rd), r.exp);
			end
		endcase
	endtask

	initial begin
		rst_n  = 1'b0;
		cs_n   = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		a0     = 1'b0;
		a1     = 1'b0;
		d_in   = '0;
		clk    = '0;
		gate   = '1;
		errors = 0;
		seed   = 85555;
		for (int i = 0; i < NUM_CH; i++) begin
			m_mode[i]   = 0;
			m_n[i]      = 1;
			m_e[i]      = 0;
			m_forced[i] = 0;
		end

		// Mode 0, 2, 3 and 7 patterns
		rows.push_back(mk(OP_CFG, 0, 3, 0, 5, 0));
		rows.push_back(mk(OP_RUN, 1, 0, 0, 8, 0));
		rows.push_back(mk(OP_CFG, 1, 1, 2, 3, 0));
		rows.push_back(mk(OP_RUN, 2, 0, 0, 7, 0));
		rows.push_back(mk(OP_CFG, 2, 1, 3, 5, 0));
		rows.push_back(mk(OP_RUN, 4, 0, 0, 11, 0));
		rows.push_back(mk(OP_CFG, 2, 1, 7, 4, 0));
		rows.push_back(mk(OP_RUN, 4, 0, 0, 9, 0));
		// Latch then live readback, 0x0123 less 3 and less 6
		rows.push_back(mk(OP_CFG, 0, 3, 0, 'h123, 0));
		rows.push_back(mk(OP_RUN, 1, 0, 0, 4, 0));
		rows.push_back(mk(OP_LATCH, 0, 0, 0, 0, 0));
		rows.push_back(mk(OP_RUN, 1, 0, 0, 3, 0));
		rows.push_back(mk(OP_READ, 0, 0, 0, 0, 'h20));
		rows.push_back(mk(OP_READ, 0, 0, 0, 0, 'h01));
		rows.push_back(mk(OP_READ, 0, 0, 0, 0, 'h1d));
		rows.push_back(mk(OP_READ, 0, 0, 0, 0, 'h01));
		// MSB only write of 2 counts from 512
		rows.push_back(mk(OP_CFG, 1, 2, 0, 2, 0));
		rows.push_back(mk(OP_RUN, 2, 0, 0, 2, 0));
		rows.push_back(mk(OP_READ, 1, 0, 0, 0, 'h01));
		// LSB only write drops an old upper byte
		rows.push_back(mk(OP_CFG, 1, 3, 0, 'h305, 0));
		rows.push_back(mk(OP_CFG, 1, 1, 0, 4, 0));
		rows.push_back(mk(OP_RUN, 2, 0, 0, 6, 0));
		rows.push_back(mk(OP_READ, 1, 0, 0, 0, 'h00));
		// Gate low on channel 0 while the others keep running
		rows.push_back(mk(OP_CFG, 0, 3, 3, 6, 0));
		rows.push_back(mk(OP_CFG, 1, 1, 2, 3, 0));
		rows.push_back(mk(OP_CFG, 2, 1, 0, 4, 0));
		rows.push_back(mk(OP_RUN, 7, 0, 0, 4, 0));
		rows.push_back(mk(OP_GATE, 0, 0, 0, 0, 0));
		rows.push_back(mk(OP_RUN, 7, 0, 0, -1, 0));
		rows.push_back(mk(OP_LATCH, 0, 0, 0, 0, 0));
		rows.push_back(mk(OP_READ, 0, 0, 0, 0, 'h03));
		rows.push_back(mk(OP_READ, 0, 0, 0, 0, 'h00));
		rows.push_back(mk(OP_GATE, 0, 0, 0, 1, 0));
		rows.push_back(mk(OP_RUN, 7, 0, 0, 3, 0));

		repeat (10) @(posedge ZCLK);
		@(negedge ZCLK);
		rst_n = 1'b1;
		repeat (2) @(negedge ZCLK);
		check_outs();
		check_val("d_oe", int'(d_oe), 0);

		foreach (rows[k])
			apply_row(rows[k]);

		$display("Checks done, error count %0d", errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: pit_8253.f
pit_pkg.sv
pit_bus_decode.sv
pit_clk_sync.sv
pit_count_load.sv
pit_down_counter.sv
pit_read_port.sv
pit_8253.sv
pit_8253_props.sv
tb_pit_8253.sv

// File: Makefile
# Verilator flow for the PIT testbench

TOP := tb_pit_8253

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f pit_8253.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f pit_8253.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "ERRORS FOUND" sim.log; then \
		echo "Simulation failed"; exit 1; \
	fi
	@grep -q "NO ERRORS" sim.log || { echo "Simulation did not complete"; exit 1; }

clean:
	rm -rf obj_dir sim.log
